// ==== source/vram_pkg.sv ====
`default_nettype none

package vram_pkg;

    // ############################################################
    // Memory geometry
    // ############################################################
    localparam int LANES         = 4;              // Addresses per request
    localparam int NUM_BANKS     = 2;              // Power of two, at most LANES
    localparam int VECTOR_LENGTH = 1024;           // Words in the whole memory
    localparam int DATA_W        = 32;

    localparam int ADDR_W = $clog2(VECTOR_LENGTH);
    localparam int BANK_W = $clog2(NUM_BANKS);     // Low address bits pick the bank
    localparam int ROW_W  = ADDR_W - BANK_W;       // Row inside one bank
    localparam int LANE_W = $clog2(LANES);

    // ############################################################
    // Shared types
    // ############################################################
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    typedef addr_t [LANES-1:0] addr_vec_t;         // Lane 0 in the low bits
    typedef data_t [LANES-1:0] data_vec_t;

    // One lane operation sent to one bank
    typedef struct packed {
        logic              valid;
        logic              we;                     // High for a write
        logic [LANE_W-1:0] lane;                   // Lane the op belongs to
        logic [ROW_W-1:0]  row;
        data_t             data;                   // Unused on reads
    } bank_op_t;

    // Read word returned by a bank
    typedef struct packed {
        logic              valid;
        logic [LANE_W-1:0] lane;                   // Slot in the result vector
        data_t             data;
    } bank_rsp_t;

endpackage

`default_nettype wire

// ==== source/vram_bank.sv ====
`default_nettype none

module vram_bank (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire vram_pkg::bank_op_t op_i,
    output vram_pkg::bank_rsp_t     rsp_o
);

    vram_pkg::data_t                mem [2**vram_pkg::ROW_W];
    vram_pkg::data_t                rd_data_q;
    logic [vram_pkg::LANE_W-1:0]    rd_lane_q;
    logic                           rd_valid_q;
    logic                           rd_en;

    assign rd_en = op_i.valid && !op_i.we;

    // Single port, write or read per cycle
    always_ff @(posedge clk)
    begin
        if (op_i.valid && op_i.we)
            mem[op_i.row] <= op_i.data;
        if (rd_en)
        begin
            rd_data_q <= mem[op_i.row];
            rd_lane_q <= op_i.lane;             // Tag travels with the word
        end
    end

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
            rd_valid_q <= 1'b0;
        else
            rd_valid_q <= rd_en;                // One-cycle response strobe
    end

    always_comb
    begin
        rsp_o.valid = rd_valid_q;
        rsp_o.lane  = rd_lane_q;
        rsp_o.data  = rd_data_q;
    end

endmodule

`default_nettype wire

// ==== source/vram_lane_sched.sv ====
`default_nettype none

module vram_lane_sched (
    input  wire                                           clk,
    input  wire                                           rst_n_i,

    input  wire vram_pkg::addr_vec_t                      waddr_i,
    input  wire vram_pkg::data_vec_t                      wdata_i,
    input  wire                                           wvalid_i,
    output logic                                          wready_o,

    input  wire vram_pkg::addr_vec_t                      raddr_i,
    input  wire                                           arvalid_i,
    output logic                                          arready_o,

    input  wire                                           gather_busy_i,
    output vram_pkg::bank_op_t [vram_pkg::NUM_BANKS-1:0]  bank_op_o,
    output logic                                          rd_start_o
);

    vram_pkg::addr_vec_t            addr_q;     // Held request addresses
    vram_pkg::data_vec_t            data_q;     // Held write data
    logic                           we_q;
    logic [vram_pkg::LANES-1:0]     pend_q;     // Lanes not yet issued
    logic [vram_pkg::LANES-1:0]     issued;     // Lanes sent to a bank this cycle
    logic                           idle;
    logic                           accept_w;
    logic                           accept_r;

    // ############################################################
    // Request acceptance
    // ############################################################
    assign idle       = (pend_q == '0) && !gather_busy_i;
    assign wready_o   = idle;
    assign arready_o  = idle && !wvalid_i;      // Write wins a tie
    assign accept_w   = wvalid_i && wready_o;
    assign accept_r   = arvalid_i && arready_o;
    assign rd_start_o = accept_r;               // Arms the gather block

    always_ff @(posedge clk)
    begin
        if (accept_w || accept_r)
        begin
            addr_q <= accept_w ? waddr_i : raddr_i;
            data_q <= wdata_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            we_q   <= 1'b0;
            pend_q <= '0;
        end
        else if (accept_w || accept_r)
        begin
            we_q   <= accept_w;
            pend_q <= '1;                       // Every lane starts pending
        end
        else
        begin
            pend_q <= pend_q & ~issued;
        end
    end

    // ############################################################
    // Per-bank issue
    // ############################################################
    // Each bank takes its lowest pending lane, so same-bank lanes go in order
    always_comb
    begin
        logic hit;
        issued = '0;
        for (int b = 0; b < vram_pkg::NUM_BANKS; b++)
        begin
            hit          = 1'b0;
            bank_op_o[b] = '0;
            for (int l = 0; l < vram_pkg::LANES; l++)
            begin
                if (!hit && pend_q[l] &&
                    (addr_q[l][vram_pkg::BANK_W-1:0] == b[vram_pkg::BANK_W-1:0]))
                begin
                    hit                = 1'b1;
                    issued[l]          = 1'b1;
                    bank_op_o[b].valid = 1'b1;
                    bank_op_o[b].we    = we_q;
                    bank_op_o[b].lane  = l[vram_pkg::LANE_W-1:0];
                    bank_op_o[b].row   = addr_q[l][vram_pkg::ADDR_W-1:vram_pkg::BANK_W];
                    bank_op_o[b].data  = data_q[l];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/vram_gather.sv ====
`default_nettype none

module vram_gather (
    input  wire                                            clk,
    input  wire                                            rst_n_i,
    input  wire                                            rd_start_i,
    input  wire vram_pkg::bank_rsp_t [vram_pkg::NUM_BANKS-1:0] rsp_i,
    output vram_pkg::data_vec_t                            rdata_o,
    output logic                                           rvalid_o,
    input  wire                                            rready_i,
    output logic                                           busy_o
);

    vram_pkg::data_vec_t            data_q;
    logic [vram_pkg::LANES-1:0]     got_q;      // Lanes already collected
    logic [vram_pkg::LANES-1:0]     got_nxt;
    logic                           rvalid_q;
    logic                           busy_q;

    always_comb
    begin
        got_nxt = got_q;
        for (int b = 0; b < vram_pkg::NUM_BANKS; b++)
        begin
            if (rsp_i[b].valid)
                got_nxt[rsp_i[b].lane] = 1'b1;
        end
    end

    // Words land in their lane slot, banks never share a lane in one cycle
    always_ff @(posedge clk)
    begin
        for (int b = 0; b < vram_pkg::NUM_BANKS; b++)
        begin
            if (rsp_i[b].valid)
                data_q[rsp_i[b].lane] <= rsp_i[b].data;
        end
    end

    // ############################################################
    // Collect and hand off
    // ############################################################
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            got_q    <= '0;
            rvalid_q <= 1'b0;
            busy_q   <= 1'b0;
        end
        else if (rd_start_i)
        begin
            got_q    <= '0;
            rvalid_q <= 1'b0;
            busy_q   <= 1'b1;
        end
        else if (rvalid_q)
        begin
            if (rready_i)                       // Vector taken
            begin
                rvalid_q <= 1'b0;
                busy_q   <= 1'b0;
            end
        end
        else if (busy_q)
        begin
            got_q    <= got_nxt;
            rvalid_q <= &got_nxt;               // All lanes in
        end
    end

    assign rdata_o  = data_q;
    assign rvalid_o = rvalid_q;
    assign busy_o   = busy_q;

endmodule

`default_nettype wire

// ==== source/vector_ram.sv ====
`default_nettype none

module vector_ram (
    input  wire                         clk,
    input  wire                         rst_n_i,

    // Write channel
    input  wire vram_pkg::addr_vec_t    waddr_i,
    input  wire vram_pkg::data_vec_t    wdata_i,
    input  wire                         wvalid_i,
    output wire                         wready_o,

    // Read request channel
    input  wire vram_pkg::addr_vec_t    raddr_i,
    input  wire                         arvalid_i,
    output wire                         arready_o,

    // Read data channel
    output wire vram_pkg::data_vec_t    rdata_o,
    output wire                         rvalid_o,
    input  wire                         rready_i
);

    wire vram_pkg::bank_op_t  [vram_pkg::NUM_BANKS-1:0] bank_op;
    wire vram_pkg::bank_rsp_t [vram_pkg::NUM_BANKS-1:0] bank_rsp;
    wire                                                rd_start;
    wire                                                gather_busy;

    // ############################################################
    // Decode
    // ############################################################
    vram_lane_sched i_vram_lane_sched (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .waddr_i       (waddr_i),
        .wdata_i       (wdata_i),
        .wvalid_i      (wvalid_i),
        .wready_o      (wready_o),
        .raddr_i       (raddr_i),
        .arvalid_i     (arvalid_i),
        .arready_o     (arready_o),
        .gather_busy_i (gather_busy),
        .bank_op_o     (bank_op),
        .rd_start_o    (rd_start)
    );

    // ############################################################
    // Execute, one RAM per bank
    // ############################################################
    for (genvar b = 0; b < vram_pkg::NUM_BANKS; b++)
    begin : g_bank
        vram_bank i_vram_bank (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .op_i    (bank_op[b]),
            .rsp_o   (bank_rsp[b])
        );
    end

    // ############################################################
    // Result
    // ############################################################
    vram_gather i_vram_gather (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rd_start_i (rd_start),
        .rsp_i      (bank_rsp),
        .rdata_o    (rdata_o),
        .rvalid_o   (rvalid_o),
        .rready_i   (rready_i),
        .busy_o     (gather_busy)
    );

endmodule

`default_nettype wire

// ==== bench/vector_ram_tb.sv ====
`default_nettype none

module vector_ram_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LANES       = vram_pkg::LANES;
    localparam int FILL_VECS   = vram_pkg::VECTOR_LENGTH / LANES;
    localparam int CONF_PAIRS  = 32;            // Write plus read each
    localparam int DUP_PAIRS   = 16;
    localparam int BP_READS    = 16;
    localparam int PRIO_PAIRS  = 16;
    localparam int TOTAL_REQS  = 2 * FILL_VECS + 2 * CONF_PAIRS + 2 * DUP_PAIRS
                                 + BP_READS + 2 * PRIO_PAIRS;
    localparam int CYCLE_LIMIT = TOTAL_REQS * 8 + 200;
    localparam int VEC_W       = LANES * vram_pkg::DATA_W;

    typedef logic [VEC_W-1:0] vec_t;

    logic                   clk;
    logic                   rst_n_i;
    vram_pkg::addr_vec_t    waddr_i;
    vram_pkg::data_vec_t    wdata_i;
    logic                   wvalid_i;
    wire                    wready_o;
    vram_pkg::addr_vec_t    raddr_i;
    logic                   arvalid_i;
    wire                    arready_o;
    vram_pkg::data_vec_t    rdata_o;
    wire                    rvalid_o;
    logic                   rready_i;

    vram_pkg::data_t        model_mem [vram_pkg::VECTOR_LENGTH];   // Flat reference memory
    int                     cycle_cnt = 0;

    vector_ram i_vector_ram (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .waddr_i   (waddr_i),
        .wdata_i   (wdata_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .raddr_i   (raddr_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .rdata_o   (rdata_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT)
        begin
            $display("Timeout after %0d cycles, a handshake never completed", CYCLE_LIMIT);
            $display("Test failed");
            $fatal(1, "Run aborted by timeout");
        end
    end

    // ############################################################
    // Helpers
    // ############################################################
    task automatic check_value(input string name, input vec_t expected, input vec_t actual);
        if (expected !== actual)
        begin
            $display("** Error: %s: expected %0h, actual %0h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Entered just after a falling edge with valid driven, returns after the transfer edge
    task automatic wait_accept(input logic is_write);
        logic ready;
        ready = 1'b0;
        while (!ready)
        begin
            #1;                                 // Let ready settle after the drive
            ready = is_write ? wready_o : arready_o;
            if (!ready)
                @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic write_vector(input vram_pkg::addr_vec_t addr, input vram_pkg::data_vec_t data);
        waddr_i  = addr;
        wdata_i  = data;
        wvalid_i = 1'b1;
        wait_accept(1'b1);
        for (int l = 0; l < LANES; l++)
            model_mem[addr[l]] = data[l];       // Ascending lane order, last lane wins
        @(negedge clk);
        wvalid_i = 1'b0;
        check_value("write busy wready", '0, vec_t'(wready_o));
        while (!wready_o)
        begin
            check_value("write busy arready", '0, vec_t'(arready_o));
            @(negedge clk);
        end
    endtask

    task automatic read_vector(input string name, input vram_pkg::addr_vec_t addr, input int hold);
        vram_pkg::data_vec_t exp_vec;
        vram_pkg::data_vec_t held;
        raddr_i   = addr;
        arvalid_i = 1'b1;
        wait_accept(1'b0);
        for (int l = 0; l < LANES; l++)
            exp_vec[l] = model_mem[addr[l]];    // Snapshot at accept
        @(negedge clk);
        arvalid_i = 1'b0;
        while (!rvalid_o)
        begin
            check_value("read busy wready", '0, vec_t'(wready_o));
            check_value("read busy arready", '0, vec_t'(arready_o));
            @(negedge clk);
        end
        held = rdata_o;
        repeat (hold)
        begin
            check_value("stall wready", '0, vec_t'(wready_o));
            check_value("stall arready", '0, vec_t'(arready_o));
            @(negedge clk);
            check_value("stall rvalid", vec_t'(1), vec_t'(rvalid_o));
            check_value("stall rdata", held, rdata_o);
        end
        check_value({name, " rvalid"}, vec_t'(1), vec_t'(rvalid_o));
        check_value(name, exp_vec, rdata_o);
        rready_i = 1'b1;
        @(posedge clk);
        @(negedge clk);
        rready_i = 1'b0;
    endtask

    function automatic vram_pkg::data_vec_t rand_data();
        vram_pkg::data_vec_t d;
        for (int l = 0; l < LANES; l++)
            d[l] = $urandom;
        return d;
    endfunction

    // Mode 0 puts all lanes in one bank, mode 1 all but lane 0, other modes are random
    function automatic vram_pkg::addr_vec_t conflict_addr(input int mode);
        vram_pkg::addr_vec_t         a;
        logic [vram_pkg::BANK_W-1:0] bank;
        bank = vram_pkg::BANK_W'($urandom);
        for (int l = 0; l < LANES; l++)
        begin
            a[l] = vram_pkg::addr_t'($urandom);
            if (mode == 0 || (mode == 1 && l != 0))
                a[l][vram_pkg::BANK_W-1:0] = bank;
        end
        return a;
    endfunction

    // ############################################################
    // Test sequence
    // ############################################################
    initial
    begin
        vram_pkg::addr_vec_t a;
        vram_pkg::addr_vec_t ra;
        int                  order [FILL_VECS];
        int                  j;
        int                  k;
        int                  tmp;

        void'($urandom(32'heba9_1a48));
        rst_n_i   = 1'b0;
        waddr_i   = '0;
        wdata_i   = '0;
        wvalid_i  = 1'b0;
        raddr_i   = '0;
        arvalid_i = 1'b0;
        rready_i  = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        check_value("reset wready", vec_t'(1), vec_t'(wready_o));
        check_value("reset arready", vec_t'(1), vec_t'(arready_o));
        check_value("reset rvalid", '0, vec_t'(rvalid_o));

        // Fill every word, then read back in shuffled order
        for (int v = 0; v < FILL_VECS; v++)
        begin
            for (int l = 0; l < LANES; l++)
                a[l] = vram_pkg::addr_t'(v * LANES + l);
            write_vector(a, rand_data());
            order[v] = v;
        end
        for (int i = FILL_VECS - 1; i > 0; i--)
        begin
            j        = int'($urandom % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int v = 0; v < FILL_VECS; v++)
        begin
            for (int l = 0; l < LANES; l++)
                a[l] = vram_pkg::addr_t'(order[v] * LANES + l);
            read_vector("fill readback", a, 0);
        end

        for (int i = 0; i < CONF_PAIRS; i++)
        begin
            write_vector(conflict_addr(i % 3), rand_data());
            read_vector("bank conflict", conflict_addr(int'($urandom % 3)), 0);
        end

        // Duplicates, sometimes every lane on one address
        for (int i = 0; i < DUP_PAIRS; i++)
        begin
            a    = conflict_addr(2);
            j    = 1 + int'($urandom % (LANES - 1));
            k    = int'($urandom % j);
            a[j] = a[k];
            if ($urandom % 4 == 0)
                a = {LANES{a[0]}};
            write_vector(a, rand_data());
            read_vector("duplicate address", a, 0);
        end

        for (int i = 0; i < BP_READS; i++)
            read_vector("back-pressure", conflict_addr(2), 1 + int'($urandom % 4));

        // Write and overlapping read offered together
        for (int i = 0; i < PRIO_PAIRS; i++)
        begin
            a = conflict_addr(int'($urandom % 3));
            for (int l = 0; l < LANES; l++)
                ra[l] = a[(l + 1) % LANES];     // Rotated lanes, same words
            ra[0]     = vram_pkg::addr_t'($urandom);
            waddr_i   = a;
            wdata_i   = rand_data();
            wvalid_i  = 1'b1;
            raddr_i   = ra;
            arvalid_i = 1'b1;
            #1;
            check_value("priority wready", vec_t'(1), vec_t'(wready_o));
            check_value("priority arready", '0, vec_t'(arready_o));
            @(posedge clk);
            for (int l = 0; l < LANES; l++)
                model_mem[a[l]] = wdata_i[l];
            @(negedge clk);
            wvalid_i = 1'b0;
            read_vector("write priority", ra, 0);
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
source/vram_pkg.sv
source/vram_bank.sv
source/vram_lane_sched.sv
source/vram_gather.sv
source/vector_ram.sv
bench/vector_ram_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the vector RAM testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
    -f sim.f \
    --top-module vector_ram_tb \
    -o vector_ram_sim

# The simulation exits nonzero on failure, the log decides the result
./obj_dir/vector_ram_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
    echo "Simulation PASS"
    exit 0
else
    echo "Simulation FAIL"
    exit 1
fi
